// File: Bender.yml
package:
  name: mem_port

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/mem_bus_pkg.sv
      - design/mem_client_if.sv
      - design/fetch_unit.sv
      - design/data_port.sv
      - design/mem_arbiter.sv
      - design/mem_port_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/mem_port_properties.sv
      - test/mem_port_tb.sv

// File: design/data_port.sv
// load/store data port
// registers one access, presents it on the bus and reports completion

`default_nettype none

`include "mem_bus_defs.svh"

module data_port (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        data_req,
    input  mem_bus_pkg::bus_command_e   data_command,
    input  logic [`MEM_ADDR_WIDTH-1:0]  data_addr,
    input  logic [`MEM_DATA_WIDTH-1:0]  data_wdata,
    output logic                        data_ready,
    output logic                        data_done,
    output logic [`MEM_DATA_WIDTH-1:0]  data_rdata,
    mem_client_if.client                bus
);
    import mem_bus_pkg::*;

    data_state_e                 state;
    // captured access
    bus_command_e                cmd_q;
    logic [`MEM_ADDR_WIDTH-1:0]  addr_q;
    logic [`MEM_DATA_WIDTH-1:0]  wdata_q;
    logic                        take;

    // new access only from idle, a none command is dropped
    assign take = data_req && data_ready && (data_command != BUS_NONE);

    assign data_ready = (state == DATA_IDLE);

    // command only while waiting for acceptance
    assign bus.command = (state == DATA_REQUEST) ? cmd_q : BUS_NONE;
    assign bus.addr    = addr_q;
    assign bus.wdata   = wdata_q;

    // stores finish on acceptance, loads on their reply
    assign data_done = ((state == DATA_REQUEST) && bus.accepted && (cmd_q == BUS_STORE))
                     || ((state == DATA_WAIT) && bus.reply_valid);
    assign data_rdata = bus.rdata;

    // access payload
    always_ff @(posedge clock) begin
        if (take) begin
            cmd_q   <= data_command;
            addr_q  <= data_addr;
            wdata_q <= data_wdata;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // access FSM
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= DATA_IDLE;
        end else begin
            case (state)
                DATA_IDLE: begin
                    if (take) begin
                        state <= DATA_REQUEST;
                    end
                end
                DATA_REQUEST: begin
                    // refused requests just sit here
                    if (bus.accepted) begin
                        state <= (cmd_q == BUS_LOAD) ? DATA_WAIT : DATA_IDLE;
                    end
                end
                DATA_WAIT: begin
                    if (bus.reply_valid) begin
                        state <= DATA_IDLE;
                    end
                end
                default: begin
                    state <= DATA_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
// sequential instruction fetch
// walks the address space one bus word at a time with one load in flight

`default_nettype none

`include "mem_bus_defs.svh"

module fetch_unit (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        hold,
    mem_client_if.client                bus,
    output logic                        fetch_valid,
    output logic [`MEM_ADDR_WIDTH-1:0]  fetch_addr,
    output logic [`MEM_DATA_WIDTH-1:0]  fetch_data
);
    import mem_bus_pkg::*;

    fetch_state_e                state;
    // program counter
    logic [`MEM_ADDR_WIDTH-1:0]  pc;
    // request raised last cycle and still not taken
    logic                        req_pending;
    logic                        req_on;

    // hold only blocks new requests
    // a refused request stays up so the bus sees it unchanged
    assign req_on = (state == FETCH_REQUEST) && (!hold || req_pending);

    // bus side, fetch only ever loads
    assign bus.command = req_on ? BUS_LOAD : BUS_NONE;
    assign bus.addr    = pc;
    assign bus.wdata   = '0;

    // reply goes straight out in its own cycle
    assign fetch_valid = (state == FETCH_WAIT) && bus.reply_valid;
    assign fetch_addr  = pc;
    assign fetch_data  = bus.rdata;

    ///////////////////////////////////////////////////////////////////////
    // fetch FSM and program counter
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= FETCH_REQUEST;
            pc          <= `FETCH_RESET_ADDR;
            req_pending <= 1'b0;
        end else begin
            req_pending <= req_on && !bus.accepted;
            case (state)
                FETCH_REQUEST: begin
                    // memory gave a tag, wait for the data
                    if (req_on && bus.accepted) begin
                        state <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    // step to the next word once the reply is out
                    if (bus.reply_valid) begin
                        state <= FETCH_REQUEST;
                        pc    <= pc + `FETCH_STEP;
                    end
                end
                default: begin
                    state <= FETCH_REQUEST;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/mem_arbiter.sv
// memory bus arbiter for fetch and data requesters
// data wins the bus, a tag owner table routes each reply back

`default_nettype none

`include "mem_bus_defs.svh"

module mem_arbiter (
    input  logic                        clock,
    input  logic                        reset,
    mem_client_if.arbiter               fetch,
    mem_client_if.arbiter               data,
    output mem_bus_pkg::bus_command_e   mem_command,
    output logic [`MEM_ADDR_WIDTH-1:0]  mem_addr,
    output logic [`MEM_DATA_WIDTH-1:0]  mem_wdata,
    input  logic [`MEM_TAG_WIDTH-1:0]   mem_response,
    input  logic [`MEM_TAG_WIDTH-1:0]   mem_tag,
    input  logic [`MEM_DATA_WIDTH-1:0]  mem_rdata
);
    import mem_bus_pkg::*;

    // owner of each outstanding load tag
    owner_e  owner_table [`MEM_TAG_COUNT];

    logic    data_grant;
    logic    resp_ok;
    logic    reply_seen;
    owner_e  reply_owner;
    owner_e  grant_owner;

    ///////////////////////////////////////////////////////////////////////
    // grant and acceptance
    ///////////////////////////////////////////////////////////////////////

    // data first, fetch gets whatever is left
    assign data_grant  = (data.command != BUS_NONE);
    assign grant_owner = data_grant ? OWN_DATA : OWN_FETCH;

    assign mem_command = data_grant ? data.command : fetch.command;
    assign mem_addr    = data_grant ? data.addr    : fetch.addr;
    assign mem_wdata   = data_grant ? data.wdata   : fetch.wdata;

    // nonzero response means taken
    assign resp_ok = (mem_response != '0);

    assign data.accepted  = data_grant && resp_ok;
    assign fetch.accepted = !data_grant && (fetch.command != BUS_NONE) && resp_ok;

    ///////////////////////////////////////////////////////////////////////
    // reply routing
    ///////////////////////////////////////////////////////////////////////

    assign reply_seen  = (mem_tag != '0);
    assign reply_owner = owner_table[mem_tag];

    assign data.reply_valid  = reply_seen && (reply_owner == OWN_DATA);
    assign fetch.reply_valid = reply_seen && (reply_owner == OWN_FETCH);

    // both see the same data, reply_valid picks the reader
    assign data.rdata  = mem_rdata;
    assign fetch.rdata = mem_rdata;

    // free on reply, then record a new load
    // the memory never reissues a live tag so the two never collide
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `MEM_TAG_COUNT; i++) begin
                owner_table[i] <= OWN_NONE;
            end
        end else begin
            if (reply_seen) begin
                owner_table[mem_tag] <= OWN_NONE;
            end
            // stores get no reply so no entry
            if (resp_ok && (mem_command == BUS_LOAD)) begin
                owner_table[mem_response] <= grant_owner;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mem_bus_defs.svh
// memory bus widths and fetch constants
// shared by the fetch unit, data port, arbiter and top level

`ifndef MEM_BUS_DEFS_SVH
`define MEM_BUS_DEFS_SVH

// byte address width
`define MEM_ADDR_WIDTH 32

// bus data width
`define MEM_DATA_WIDTH 64

// response and reply tag width
`define MEM_TAG_WIDTH 4

// number of tag values, tag zero means none
`define MEM_TAG_COUNT 16

// byte step between sequential fetches
`define FETCH_STEP 32'd8

// first fetch address out of reset
`define FETCH_RESET_ADDR 32'h0000_0000

`endif

// File: design/mem_bus_pkg.sv
// memory bus types
// bus commands, tag owners and the client state machines

`default_nettype none

package mem_bus_pkg;

    // bus command encodings
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_e;

    // who is waiting on a given tag
    typedef enum logic [1:0] {
        OWN_NONE  = 2'h0,
        OWN_DATA  = 2'h1,
        OWN_FETCH = 2'h2
    } owner_e;

    // fetch unit states
    typedef enum logic {
        FETCH_REQUEST = 1'b0,
        FETCH_WAIT    = 1'b1
    } fetch_state_e;

    // data port states
    typedef enum logic [1:0] {
        DATA_IDLE    = 2'h0,
        DATA_REQUEST = 2'h1,
        DATA_WAIT    = 2'h2
    } data_state_e;

endpackage

`default_nettype wire

// File: design/mem_client_if.sv
// link between one memory requester and the arbiter
// request side from the client, acceptance and replies from the arbiter

`default_nettype none

`include "mem_bus_defs.svh"

interface mem_client_if;
    import mem_bus_pkg::*;

    ///////////////////////////////////////////////////////////////////////
    // request side
    ///////////////////////////////////////////////////////////////////////

    // held steady until accepted
    bus_command_e                command;
    logic [`MEM_ADDR_WIDTH-1:0]  addr;
    logic [`MEM_DATA_WIDTH-1:0]  wdata;

    ///////////////////////////////////////////////////////////////////////
    // response side
    ///////////////////////////////////////////////////////////////////////

    // one cycle pulse when the memory took this client's request
    logic                        accepted;
    // load data, qualified by reply_valid
    logic [`MEM_DATA_WIDTH-1:0]  rdata;
    // one cycle pulse when a reply for this client returns
    logic                        reply_valid;

    modport client (
        output command, addr, wdata,
        input  accepted, rdata, reply_valid
    );

    modport arbiter (
        input  command, addr, wdata,
        output accepted, rdata, reply_valid
    );

endinterface

`default_nettype wire

// File: design/mem_port_top.sv
// memory side of the front end
// fetch unit and data port sharing one tagged memory bus

`default_nettype none

`include "mem_bus_defs.svh"

module mem_port_top (
    input  logic                        clock,
    input  logic                        reset,
    // fetch control and stream
    input  logic                        hold,
    output logic                        fetch_valid,
    output logic [`MEM_ADDR_WIDTH-1:0]  fetch_addr,
    output logic [`MEM_DATA_WIDTH-1:0]  fetch_data,
    // load/store requests
    input  logic                        data_req,
    input  mem_bus_pkg::bus_command_e   data_command,
    input  logic [`MEM_ADDR_WIDTH-1:0]  data_addr,
    input  logic [`MEM_DATA_WIDTH-1:0]  data_wdata,
    output logic                        data_ready,
    output logic                        data_done,
    output logic [`MEM_DATA_WIDTH-1:0]  data_rdata,
    // memory bus
    output mem_bus_pkg::bus_command_e   mem_command,
    output logic [`MEM_ADDR_WIDTH-1:0]  mem_addr,
    output logic [`MEM_DATA_WIDTH-1:0]  mem_wdata,
    input  logic [`MEM_TAG_WIDTH-1:0]   mem_response,
    input  logic [`MEM_DATA_WIDTH-1:0]  mem_rdata,
    input  logic [`MEM_TAG_WIDTH-1:0]   mem_tag
);

    // one link per requester
    mem_client_if fetch_bus ();
    mem_client_if data_bus ();

    fetch_unit fetch_unit_inst (
        .clock       (clock),
        .reset       (reset),
        .hold        (hold),
        .bus         (fetch_bus.client),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data)
    );

    data_port data_port_inst (
        .clock        (clock),
        .reset        (reset),
        .data_req     (data_req),
        .data_command (data_command),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_ready   (data_ready),
        .data_done    (data_done),
        .data_rdata   (data_rdata),
        .bus          (data_bus.client)
    );

    mem_arbiter mem_arbiter_inst (
        .clock        (clock),
        .reset        (reset),
        .fetch        (fetch_bus.arbiter),
        .data         (data_bus.arbiter),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_rdata    (mem_rdata)
    );

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/mem_bus_pkg.sv
design/mem_client_if.sv
design/fetch_unit.sv
design/data_port.sv
design/mem_arbiter.sv
design/mem_port_top.sv
test/mem_port_properties.sv
test/mem_port_tb.sv

// File: test/mem_port_properties.sv
// arbiter protocol assertions
// request stability, reply ownership and fresh tags on acceptance

`default_nettype none

`include "mem_bus_defs.svh"

module mem_port_properties (
    input logic                        clock,
    input logic                        reset,
    input mem_bus_pkg::bus_command_e   fetch_command,
    input logic [`MEM_ADDR_WIDTH-1:0]  fetch_addr,
    input logic                        fetch_accepted,
    input mem_bus_pkg::bus_command_e   data_command,
    input logic [`MEM_ADDR_WIDTH-1:0]  data_addr,
    input logic                        data_accepted,
    input logic [`MEM_TAG_WIDTH-1:0]   mem_tag,
    input mem_bus_pkg::owner_e         reply_owner,
    input mem_bus_pkg::owner_e         response_owner
);
    timeunit 1ns;
    timeprecision 100ps;
    import mem_bus_pkg::*;

    // failed assertions so far
    int failures = 0;

    // fetch request stays put until taken
    fetch_stable: assert property (@(posedge clock) disable iff (reset)
        (fetch_command != BUS_NONE && !fetch_accepted) |=>
        (fetch_command == $past(fetch_command) && fetch_addr == $past(fetch_addr)))
        else begin
            $error("fetch request changed before acceptance");
            failures++;
        end

    // same for the data port
    data_stable: assert property (@(posedge clock) disable iff (reset)
        (data_command != BUS_NONE && !data_accepted) |=>
        (data_command == $past(data_command) && data_addr == $past(data_addr)))
        else begin
            $error("data request changed before acceptance");
            failures++;
        end

    // every reply tag has an owner
    reply_owned: assert property (@(posedge clock) disable iff (reset)
        (mem_tag != '0) |-> (reply_owner != OWN_NONE))
        else begin
            $error("reply tag %0d has no owner", mem_tag);
            failures++;
        end

    // an accepted tag is never one still waiting on its reply
    fresh_tag: assert property (@(posedge clock) disable iff (reset)
        (fetch_accepted || data_accepted) |-> (response_owner == OWN_NONE))
        else begin
            $error("accepted tag still owned by an earlier load");
            failures++;
        end

endmodule

bind mem_arbiter mem_port_properties mem_port_properties_inst (
    .clock          (clock),
    .reset          (reset),
    .fetch_command  (fetch.command),
    .fetch_addr     (fetch.addr),
    .fetch_accepted (fetch.accepted),
    .data_command   (data.command),
    .data_addr      (data.addr),
    .data_accepted  (data.accepted),
    .mem_tag        (mem_tag),
    .reply_owner    (reply_owner),
    .response_owner (owner_table[mem_response])
);

`default_nettype wire

// File: test/mem_port_tb.sv
// testbench for the fetch and data memory ports
// tagged memory model, access table, stream checks and watchdog

`default_nettype none

`include "mem_bus_defs.svh"

module mem_port_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_bus_pkg::*;

    localparam int          TABLE_LEN    = 12;
    localparam int          FETCH_TARGET = 40;
    localparam int          WATCHDOG     = TABLE_LEN * 64 + 200;
    localparam logic [63:0] FILL_MASK    = 64'h5a5a_0000_a5a5_0000;

    typedef struct packed {
        bus_command_e command;
        logic [31:0]  addr;
        logic [63:0]  wdata;
        logic [63:0]  rdata;
    } access_t;

    // store values land in later loads and in the fetch stream
    access_t access_table [TABLE_LEN] = '{
        '{BUS_STORE, 32'h0000_00c0, 64'h1111_2222_3333_4444, 64'h0},
        '{BUS_LOAD,  32'h0000_00c0, 64'h0, 64'h1111_2222_3333_4444},
        '{BUS_LOAD,  32'h0000_2000, 64'h0, 64'h5a5a_0000_a5a5_2000},
        '{BUS_STORE, 32'h0000_00f8, 64'hdead_beef_0bad_f00d, 64'h0},
        '{BUS_LOAD,  32'h0000_3008, 64'h0, 64'h5a5a_0000_a5a5_3008},
        '{BUS_LOAD,  32'h0000_00f8, 64'h0, 64'hdead_beef_0bad_f00d},
        '{BUS_STORE, 32'h0000_2000, 64'h0123_4567_89ab_cdef, 64'h0},
        '{BUS_LOAD,  32'h0000_2000, 64'h0, 64'h0123_4567_89ab_cdef},
        '{BUS_LOAD,  32'h0000_0040, 64'h0, 64'h5a5a_0000_a5a5_0040},
        '{BUS_LOAD,  32'h0000_7ff8, 64'h0, 64'h5a5a_0000_a5a5_7ff8},
        '{BUS_STORE, 32'h0000_7ff8, 64'h7777_8888_9999_aaaa, 64'h0},
        '{BUS_LOAD,  32'h0000_7ff8, 64'h0, 64'h7777_8888_9999_aaaa}
    };

    logic                         clock;
    logic                         reset;
    logic                         hold;
    logic                         fetch_valid;
    logic [`MEM_ADDR_WIDTH-1:0]   fetch_addr;
    logic [`MEM_DATA_WIDTH-1:0]   fetch_data;
    logic                         data_req;
    bus_command_e                 data_command;
    logic [`MEM_ADDR_WIDTH-1:0]   data_addr;
    logic [`MEM_DATA_WIDTH-1:0]   data_wdata;
    logic                         data_ready;
    logic                         data_done;
    logic [`MEM_DATA_WIDTH-1:0]   data_rdata;
    bus_command_e                 mem_command;
    logic [`MEM_ADDR_WIDTH-1:0]   mem_addr;
    logic [`MEM_DATA_WIDTH-1:0]   mem_wdata;
    logic [`MEM_TAG_WIDTH-1:0]    mem_response;
    logic [`MEM_DATA_WIDTH-1:0]   mem_rdata;
    logic [`MEM_TAG_WIDTH-1:0]    mem_tag;

    int checks;
    int errors;
    int tests_done;

    mem_port_top mem_port_top_inst (
        .clock        (clock),
        .reset        (reset),
        .hold         (hold),
        .fetch_valid  (fetch_valid),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .data_req     (data_req),
        .data_command (data_command),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_ready   (data_ready),
        .data_done    (data_done),
        .data_rdata   (data_rdata),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_response (mem_response),
        .mem_rdata    (mem_rdata),
        .mem_tag      (mem_tag)
    );

    always #4 clock = ~clock;

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s actual %h expected %h", name, actual, expected);
        end
    endtask

    // unwritten words read as address xor mask
    function automatic logic [63:0] fill_word(input logic [31:0] addr);
        return {32'h0, addr} ^ FILL_MASK;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // memory model
    ///////////////////////////////////////////////////////////////////////

    logic [63:0] mem_words [logic [31:0]];
    logic        tag_busy [`MEM_TAG_COUNT];
    logic        reply_pending [`MEM_TAG_COUNT];
    int          reply_cycle [`MEM_TAG_COUNT];
    logic [63:0] reply_word [`MEM_TAG_COUNT];
    int          model_cycle;
    int          next_tag;

    always @(posedge clock or posedge reset) begin
        int pick;
        if (reset) begin
            mem_response <= '0;
            mem_tag      <= '0;
            mem_rdata    <= '0;
            model_cycle = 0;
            next_tag    = 1;
            for (int t = 0; t < `MEM_TAG_COUNT; t++) begin
                tag_busy[t]      = 1'b0;
                reply_pending[t] = 1'b0;
            end
        end else begin
            model_cycle++;
            // tag replied in the cycle just ended is free again
            if (mem_tag != '0) begin
                tag_busy[mem_tag] = 1'b0;
            end
            // accepted request of the cycle just ended
            if (mem_response != '0 && mem_command == BUS_STORE) begin
                mem_words[mem_addr] = mem_wdata;
            end
            if (mem_response != '0 && mem_command == BUS_LOAD) begin
                tag_busy[mem_response]      = 1'b1;
                reply_pending[mem_response] = 1'b1;
                // three cycles after the accepting cycle
                reply_cycle[mem_response] = model_cycle + 2;
                reply_word[mem_response] = mem_words.exists(mem_addr) ?
                                           mem_words[mem_addr] : fill_word(mem_addr);
            end
            // oldest due reply goes out, others slip a cycle
            pick = 0;
            for (int t = 1; t < `MEM_TAG_COUNT; t++) begin
                if (reply_pending[t] && reply_cycle[t] <= model_cycle &&
                    (pick == 0 || reply_cycle[t] < reply_cycle[pick])) begin
                    pick = t;
                end
            end
            if (pick != 0) begin
                reply_pending[pick] = 1'b0;
                mem_tag   <= 4'(pick);
                mem_rdata <= reply_word[pick];
            end else begin
                mem_tag   <= '0;
                mem_rdata <= '0;
            end
            // about one in four refused
            if ($urandom_range(3) == 0) begin
                mem_response <= '0;
            end else begin
                while (tag_busy[next_tag]) begin
                    next_tag = (next_tag == 15) ? 1 : next_tag + 1;
                end
                mem_response <= 4'(next_tag);
                next_tag = (next_tag == 15) ? 1 : next_tag + 1;
            end
        end
    end

    // hold comes in short bursts
    always @(posedge clock) begin
        if (reset) begin
            hold <= 1'b0;
        end else if (hold) begin
            hold <= ($urandom_range(2) != 0);
        end else begin
            hold <= ($urandom_range(9) == 0);
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // bus and fetch stream monitor
    ///////////////////////////////////////////////////////////////////////

    logic [63:0]  ref_words [logic [31:0]];
    logic         req_phase;
    bus_command_e req_cmd;
    logic [31:0]  req_addr;
    logic [63:0]  req_wdata;
    logic         fetch_busy;
    // hold has dropped since the fetch unit went idle
    logic         fetch_free;
    logic [31:0]  exp_fetch_addr;
    int           fetch_count;

    always @(posedge clock) begin
        logic        data_granted;
        logic [63:0] exp_word;
        if (reset) begin
            req_phase      = 1'b0;
            fetch_busy     = 1'b0;
            fetch_free     = 1'b0;
            exp_fetch_addr = `FETCH_RESET_ADDR;
            fetch_count    = 0;
        end else begin
            data_granted = req_phase;
            // pending data access owns the bus
            if (req_phase) begin
                check_value("mem_command", 64'(mem_command), 64'(req_cmd));
                check_value("mem_addr", 64'(mem_addr), 64'(req_addr));
                if (req_cmd == BUS_STORE) begin
                    check_value("mem_wdata", mem_wdata, req_wdata);
                end
            end
            // an idle cycle without hold lets the next fetch go
            if (!fetch_busy && !hold) begin
                fetch_free = 1'b1;
            end
            // held ever since the last reply, no fetch on the bus
            if (!data_granted && !fetch_busy && !fetch_free) begin
                check_value("mem_command", 64'(mem_command), 64'(BUS_NONE));
            end
            if (fetch_valid) begin
                exp_word = ref_words.exists(exp_fetch_addr) ?
                           ref_words[exp_fetch_addr] : fill_word(exp_fetch_addr);
                check_value("fetch_addr", 64'(fetch_addr), 64'(exp_fetch_addr));
                check_value("fetch_data", fetch_data, exp_word);
                exp_fetch_addr = exp_fetch_addr + `FETCH_STEP;
                fetch_count++;
                fetch_busy = 1'b0;
            end
            if (mem_response != '0) begin
                if (data_granted) begin
                    req_phase = 1'b0;
                    if (req_cmd == BUS_STORE) begin
                        ref_words[req_addr] = req_wdata;
                    end
                end else if (mem_command == BUS_LOAD) begin
                    fetch_busy = 1'b1;
                    fetch_free = 1'b0;
                end
            end
            // capture edge of a new access
            if (data_req && data_ready && data_command != BUS_NONE) begin
                req_phase = 1'b1;
                req_cmd   = data_command;
                req_addr  = data_addr;
                req_wdata = data_wdata;
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // stimulus
    ///////////////////////////////////////////////////////////////////////

    task automatic run_access(input int idx);
        access_t entry;
        int      cycles;
        entry  = access_table[idx];
        cycles = 0;
        // wait for an idle port
        @(posedge clock);
        while (!data_ready) begin
            @(posedge clock);
        end
        data_req     <= 1'b1;
        data_command <= entry.command;
        data_addr    <= entry.addr;
        data_wdata   <= entry.wdata;
        @(posedge clock);
        data_req     <= 1'b0;
        data_command <= BUS_NONE;
        do begin
            @(posedge clock);
            cycles++;
        end while (!data_done);
        if (entry.command == BUS_LOAD) begin
            check_value("data_rdata", data_rdata, entry.rdata);
        end
        tests_done++;
        $display("test %0d %s addr %h done after %0d cycles", idx,
                 (entry.command == BUS_LOAD) ? "load" : "store", entry.addr, cycles);
    endtask

    initial begin
        void'($urandom(32'hebbb_00d1));
        checks       = 0;
        errors       = 0;
        tests_done   = 0;
        clock        = 1'b0;
        reset        = 1'b1;
        hold         = 1'b0;
        data_req     = 1'b0;
        data_command = BUS_NONE;
        data_addr    = '0;
        data_wdata   = '0;
        mem_response = '0;
        mem_rdata    = '0;
        mem_tag      = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < TABLE_LEN; i++) begin
            run_access(i);
        end
        // let fetch run past the stored words
        while (fetch_count < FETCH_TARGET) begin
            @(posedge clock);
        end
        // bound arbiter assertions count as errors too
        errors += mem_port_top_inst.mem_arbiter_inst.mem_port_properties_inst.failures;
        $display("%0d tests, %0d fetches, %0d checks, %0d errors",
                 tests_done, fetch_count, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG) @(posedge clock);
        $display("run timed out after %0d cycles with %0d tests done",
                 WATCHDOG, tests_done);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
